//--- Makefile
# Verilator build and run of the group norm testbench

VERILATOR ?= verilator
TOP       ?= tb_group_norm_2d
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
JOBS      ?= 0
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR TIMESCALE JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --timescale $(TIMESCALE) \
		--top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- hw/fixed_accumulator.sv
//////////////////////////////
// Fixed accumulator
// Sums NUM_ITERS beats into one total
//////////////////////////////

`include "group_norm_defines.svh"

module fixed_accumulator #(
    parameter int IN_WIDTH = 10,
    parameter bit SIGNED   = 1'b1
) (
    input  logic                           clk,
    input  logic                           reset,

    input  logic [IN_WIDTH-1:0]            data_in,
    input  logic                           data_in_valid,
    output logic                           data_in_ready,

    output logic [IN_WIDTH+`ITER_WIDTH-1:0] data_out,
    output logic                           data_out_valid,
    input  logic                           data_out_ready
);

    logic [`ITER_WIDTH-1:0] count;
    logic                   last_beat;

    assign last_beat     = count == `ITER_WIDTH'(`NUM_ITERS - 1);
    // No new beats while a total waits to be taken
    assign data_in_ready = !data_out_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            count          <= '0;
            data_out       <= '0;
            data_out_valid <= 1'b0;
        end else if (data_out_valid && data_out_ready) begin
            data_out       <= '0;
            data_out_valid <= 1'b0;
        end else if (data_in_valid && data_in_ready) begin
            data_out       <= data_out + {{`ITER_WIDTH{SIGNED & data_in[IN_WIDTH-1]}}, data_in};
            count          <= count + 1'b1;
            data_out_valid <= last_beat;
        end
    end

endmodule

//--- hw/fixed_adder_tree.sv
//////////////////////////////
// Fixed adder tree
// Reduces one tile to a registered sum
//////////////////////////////

`include "group_norm_defines.svh"

module fixed_adder_tree #(
    parameter int IN_WIDTH = 8,
    parameter bit SIGNED   = 1'b1
) (
    input  logic                            clk,
    input  logic                            reset,

    input  logic [IN_WIDTH-1:0]             data_in [`COMPUTE_SIZE],
    input  logic                            data_in_valid,
    output logic                            data_in_ready,

    output logic [IN_WIDTH+`TREE_GROWTH-1:0] data_out,
    output logic                            data_out_valid,
    input  logic                            data_out_ready
);

    localparam int OUT_WIDTH = IN_WIDTH + `TREE_GROWTH;

    logic [OUT_WIDTH-1:0] sum_comb;

    // Extension bit follows SIGNED, so one tree serves both sums and squares
    always_comb begin
        sum_comb = '0;
        for (int i = 0; i < `COMPUTE_SIZE; i++) begin
            sum_comb = sum_comb
                     + {{`TREE_GROWTH{SIGNED & data_in[i][IN_WIDTH-1]}}, data_in[i]};
        end
    end

    // Output stage holds while downstream stalls
    assign data_in_ready = !data_out_valid || data_out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            data_out_valid <= 1'b0;
        end else if (data_in_ready) begin
            data_out_valid <= data_in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (data_in_valid && data_in_ready) begin
            data_out <= sum_comb;
        end
    end

endmodule

//--- hw/group_buffer.sv
//////////////////////////////
// Group buffer
// Stores one group, replays it twice
//////////////////////////////

`include "group_norm_defines.svh"

module group_buffer import norm_types_pkg::*; (
    input  logic     clk,
    input  logic     reset,

    input  in_data_t in_data [`COMPUTE_SIZE],
    input  logic     in_valid,
    output logic     in_ready,

    input  logic     replay_en,

    output in_data_t out_data [`COMPUTE_SIZE],
    output logic     out_valid,
    input  logic     out_ready,
    output logic     out_last
);

    in_data_t mem [`NUM_ITERS][`COMPUTE_SIZE];

    logic [`ITER_WIDTH:0]   wr_count;
    logic [`ITER_WIDTH-1:0] rd_count;
    logic                   second_pass;
    logic                   full;

    assign full     = wr_count == (`ITER_WIDTH+1)'(`NUM_ITERS);
    assign in_ready = !full;

    // Reads never run ahead of writes
    assign out_valid = replay_en && ({1'b0, rd_count} < wr_count);
    assign out_data  = mem[rd_count];
    assign out_last  = rd_count == `ITER_WIDTH'(`NUM_ITERS - 1);

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            mem[wr_count[`ITER_WIDTH-1:0]] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_count    <= '0;
            rd_count    <= '0;
            second_pass <= 1'b0;
        end else begin
            if (in_valid && in_ready) begin
                wr_count <= wr_count + 1'b1;
            end
            if (out_valid && out_ready) begin
                // Read pointer wraps to zero after the last beat
                rd_count <= rd_count + 1'b1;
                if (out_last) begin
                    second_pass <= !second_pass;
                    if (second_pass) begin
                        wr_count <= '0;
                    end
                end
            end
        end
    end

endmodule

//--- hw/group_norm_2d.sv
//////////////////////////////
// Group norm over 2-D tiles
// Load, variance and normalize passes
//////////////////////////////

`include "group_norm_defines.svh"

module group_norm_2d
    import norm_types_pkg::*;
    import norm_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    input  in_data_t  in_data [`COMPUTE_SIZE],
    input  logic      in_valid,
    output logic      in_ready,

    output out_data_t out_data [`COMPUTE_SIZE],
    output logic      out_valid,
    input  logic      out_ready
);

    localparam int PROD_WIDTH = `IN_WIDTH + `RECIP_FRAC + 2;
    localparam int SAT_MAX    = 2**(`OUT_WIDTH - 1) - 1;
    localparam int SAT_MIN    = -(2**(`OUT_WIDTH - 1));

    group_phase_t phase;
    in_data_t     mean_reg;
    recip_t       recip_reg;

    logic [`IN_WIDTH-1:0] sum_tree_in [`COMPUTE_SIZE];
    logic      buf_in_ready, sum_in_ready, load_xfer;
    in_data_t  buf_out_data [`COMPUTE_SIZE];
    logic      buf_out_valid, buf_out_ready, buf_out_last, replay_xfer;

    sum_t      tile_sum;
    logic      tile_sum_valid, tile_sum_ready;
    acc_t      mean_total;
    logic      mean_valid, mean_ready;

    diff_t     diff [`COMPUTE_SIZE];
    sq_t       square_in [`COMPUTE_SIZE];
    logic      square_in_valid, square_in_ready;
    sq_sum_t   tile_sq;
    logic      tile_sq_valid, tile_sq_ready;
    sq_acc_t   sq_total;
    logic      var_valid, var_ready;
    var_t      variance;

    recip_t    recip;
    logic      recip_valid, recip_ready;

    logic signed [PROD_WIDTH-1:0] scaled [`COMPUTE_SIZE];
    out_data_t sat [`COMPUTE_SIZE];
    logic      scale_ready, scale_load;

    // A beat goes to the buffer and the sum tree together, or not at all
    assign in_ready  = phase == PHASE_LOAD && buf_in_ready && sum_in_ready;
    assign load_xfer = in_valid && in_ready;

    always_comb begin
        for (int i = 0; i < `COMPUTE_SIZE; i++) begin
            sum_tree_in[i] = in_data[i];
        end
    end

    group_buffer group_buf (
        .clk(clk), .reset(reset),
        .in_data(in_data), .in_valid(load_xfer), .in_ready(buf_in_ready),
        .replay_en(phase == PHASE_VAR || phase == PHASE_NORM),
        .out_data(buf_out_data), .out_valid(buf_out_valid),
        .out_ready(buf_out_ready), .out_last(buf_out_last)
    );

    fixed_adder_tree #(.IN_WIDTH($bits(in_data_t)), .SIGNED(1'b1)) sum_tree (
        .clk(clk), .reset(reset),
        .data_in(sum_tree_in), .data_in_valid(load_xfer), .data_in_ready(sum_in_ready),
        .data_out(tile_sum), .data_out_valid(tile_sum_valid),
        .data_out_ready(tile_sum_ready)
    );

    fixed_accumulator #(.IN_WIDTH($bits(sum_t)), .SIGNED(1'b1)) mean_acc (
        .clk(clk), .reset(reset),
        .data_in(tile_sum), .data_in_valid(tile_sum_valid), .data_in_ready(tile_sum_ready),
        .data_out(mean_total), .data_out_valid(mean_valid), .data_out_ready(mean_ready)
    );

    // Difference, square and scale for every element of the replayed beat
    always_comb begin
        for (int i = 0; i < `COMPUTE_SIZE; i++) begin
            diff[i]      = diff_t'(buf_out_data[i]) - diff_t'(mean_reg);
            square_in[i] = diff[i] * diff[i];
            scaled[i]    = (diff[i] * $signed({1'b0, recip_reg})) >>> `SCALE_SHIFT;
            if (scaled[i] > SAT_MAX) begin
                sat[i] = out_data_t'(SAT_MAX);
            end else if (scaled[i] < SAT_MIN) begin
                sat[i] = out_data_t'(SAT_MIN);
            end else begin
                sat[i] = scaled[i][`OUT_WIDTH-1:0];
            end
        end
    end

    assign square_in_valid = buf_out_valid && phase == PHASE_VAR;

    fixed_adder_tree #(.IN_WIDTH($bits(sq_t)), .SIGNED(1'b0)) square_tree (
        .clk(clk), .reset(reset),
        .data_in(square_in), .data_in_valid(square_in_valid),
        .data_in_ready(square_in_ready),
        .data_out(tile_sq), .data_out_valid(tile_sq_valid), .data_out_ready(tile_sq_ready)
    );

    fixed_accumulator #(.IN_WIDTH($bits(sq_sum_t)), .SIGNED(1'b0)) square_acc (
        .clk(clk), .reset(reset),
        .data_in(tile_sq), .data_in_valid(tile_sq_valid), .data_in_ready(tile_sq_ready),
        .data_out(sq_total), .data_out_valid(var_valid), .data_out_ready(var_ready)
    );

    assign variance = sq_total[`ELEM_SHIFT +: $bits(var_t)];

    inv_sqrt_unit isqrt (
        .clk(clk), .reset(reset),
        .in_data(variance), .in_valid(var_valid), .in_ready(var_ready),
        .out_data(recip), .out_valid(recip_valid), .out_ready(recip_ready)
    );

    assign mean_ready  = phase == PHASE_MEAN;
    assign recip_ready = phase == PHASE_SQRT;

    always_comb begin
        case (phase)
            PHASE_VAR:  buf_out_ready = square_in_ready;
            PHASE_NORM: buf_out_ready = scale_ready;
            default:    buf_out_ready = 1'b0;
        endcase
    end

    assign replay_xfer = buf_out_valid && buf_out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= PHASE_LOAD;
        end else begin
            case (phase)
                PHASE_LOAD: if (mean_valid) phase <= PHASE_MEAN;
                PHASE_MEAN: phase <= PHASE_VAR;
                PHASE_VAR:  if (replay_xfer && buf_out_last) phase <= PHASE_SQRT;
                PHASE_SQRT: if (recip_valid) phase <= PHASE_NORM;
                PHASE_NORM: if (replay_xfer && buf_out_last) phase <= PHASE_LOAD;
                default:    phase <= PHASE_LOAD;
            endcase
        end
    end

    // Mean is the arithmetic shift of the group sum
    always_ff @(posedge clk) begin
        if (mean_valid && mean_ready) begin
            mean_reg <= mean_total[`ELEM_SHIFT +: $bits(in_data_t)];
        end
        if (recip_valid && recip_ready) begin
            recip_reg <= recip;
        end
    end

    // Output register of the scale stage
    assign scale_ready = !out_valid || out_ready;
    assign scale_load  = buf_out_valid && phase == PHASE_NORM && scale_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (scale_ready) begin
            out_valid <= scale_load;
        end
    end

    always_ff @(posedge clk) begin
        if (scale_load) begin
            out_data <= sat;
        end
    end

endmodule

//--- hw/group_norm_defines.svh
//////////////////////////////
// Group norm sizes
// Tile, depth, width and shift constants
//////////////////////////////

`ifndef GROUP_NORM_DEFINES_SVH
`define GROUP_NORM_DEFINES_SVH

// Tile shape and elements per beat
`define COMPUTE_DIM0 2
`define COMPUTE_DIM1 2
`define COMPUTE_SIZE (`COMPUTE_DIM0 * `COMPUTE_DIM1)

// Beats per group and their counter width
`define NUM_ITERS 8
`define ITER_WIDTH 3

// Growth of a tile reduction, log2 of COMPUTE_SIZE
`define TREE_GROWTH 2

// log2 of elements per group
`define ELEM_SHIFT 5

// Element widths
`define IN_WIDTH 8
`define OUT_WIDTH 8
`define OUT_FRAC 5

// Reciprocal scale format
`define RECIP_FRAC 12
`define SCALE_SHIFT (`RECIP_FRAC - `OUT_FRAC)

`endif

//--- hw/inv_sqrt_unit.sv
//////////////////////////////
// Inverse square root
// Bit-serial root, then reciprocal divide
//////////////////////////////

`include "group_norm_defines.svh"

module inv_sqrt_unit
    import norm_types_pkg::*;
    import norm_ctrl_pkg::*;
(
    input  logic   clk,
    input  logic   reset,

    input  var_t   in_data,
    input  logic   in_valid,
    output logic   in_ready,

    output recip_t out_data,
    output logic   out_valid,
    input  logic   out_ready
);

    localparam int RW         = $bits(root_t);
    localparam int REM_WIDTH  = RW + 3;
    localparam int DIV_STEPS  = `RECIP_FRAC + 1;
    localparam int CNT_WIDTH  = $clog2(DIV_STEPS);

    sqrt_step_t             step;
    logic [CNT_WIDTH-1:0]   count;
    logic [2*RW-1:0]        radicand;
    logic [REM_WIDTH-1:0]   rem;
    root_t                  root;
    recip_t                 dvd;

    logic [REM_WIDTH-1:0]   root_shift;
    logic [REM_WIDTH-1:0]   root_trial;
    logic                   root_fits;
    logic [REM_WIDTH-1:0]   div_shift;
    logic [REM_WIDTH-1:0]   divisor;
    logic                   div_fits;

    // Root step brings down two radicand bits per cycle
    assign root_shift = {rem[REM_WIDTH-3:0], radicand[2*RW-1 -: 2]};
    assign root_trial = REM_WIDTH'({root, 2'b01});
    assign root_fits  = root_shift >= root_trial;

    // Divide step: 4096 / (root + 1), quotient shifts into dvd
    assign div_shift  = {rem[REM_WIDTH-2:0], dvd[`RECIP_FRAC]};
    assign divisor    = REM_WIDTH'(root) + 1'b1;
    assign div_fits   = div_shift >= divisor;

    assign in_ready  = step == STEP_IDLE;
    assign out_valid = step == STEP_DONE;
    assign out_data  = dvd;

    always_ff @(posedge clk) begin
        if (reset) begin
            step  <= STEP_IDLE;
            count <= '0;
        end else begin
            case (step)
                STEP_IDLE: if (in_valid) begin
                    step  <= STEP_ROOT;
                    count <= '0;
                end
                STEP_ROOT: begin
                    count <= count + 1'b1;
                    if (count == CNT_WIDTH'(RW - 1)) begin
                        step  <= STEP_DIV;
                        count <= '0;
                    end
                end
                STEP_DIV: begin
                    count <= count + 1'b1;
                    if (count == CNT_WIDTH'(DIV_STEPS - 1)) begin
                        step <= STEP_DONE;
                    end
                end
                STEP_DONE: if (out_ready) step <= STEP_IDLE;
                default:   step <= STEP_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (step)
            STEP_IDLE: if (in_valid) begin
                radicand <= (2*RW)'(in_data);
                rem      <= '0;
                root     <= '0;
            end
            STEP_ROOT: begin
                radicand <= radicand << 2;
                root     <= {root[RW-2:0], root_fits};
                if (count == CNT_WIDTH'(RW - 1)) begin
                    // Remainder is not needed once the root is known
                    rem <= '0;
                    dvd <= recip_t'(1) << `RECIP_FRAC;
                end else begin
                    rem <= root_fits ? root_shift - root_trial : root_shift;
                end
            end
            STEP_DIV: begin
                rem <= div_fits ? div_shift - divisor : div_shift;
                dvd <= {dvd[`RECIP_FRAC-1:0], div_fits};
            end
            default: ;
        endcase
    end

endmodule

//--- hw/norm_ctrl_pkg.sv
//////////////////////////////
// Group norm control states
//////////////////////////////

package norm_ctrl_pkg;

    // Group controller passes
    typedef enum logic [2:0] {
        PHASE_LOAD,
        PHASE_MEAN,
        PHASE_VAR,
        PHASE_SQRT,
        PHASE_NORM
    } group_phase_t;

    // Inverse square root sequencer
    typedef enum logic [1:0] {
        STEP_IDLE,
        STEP_ROOT,
        STEP_DIV,
        STEP_DONE
    } sqrt_step_t;

endpackage

//--- hw/norm_types_pkg.sv
//////////////////////////////
// Group norm data types
//////////////////////////////

`include "group_norm_defines.svh"

package norm_types_pkg;

    // Load pass
    typedef logic signed [`IN_WIDTH-1:0] in_data_t;
    typedef logic signed [`IN_WIDTH+`TREE_GROWTH-1:0] sum_t;
    typedef logic signed [`IN_WIDTH+`TREE_GROWTH+`ITER_WIDTH-1:0] acc_t;

    // Variance pass, one guard bit over the element width
    typedef logic signed [`IN_WIDTH:0] diff_t;
    typedef logic [2*`IN_WIDTH:0] sq_t;
    typedef logic [2*`IN_WIDTH+`TREE_GROWTH:0] sq_sum_t;
    typedef logic [2*`IN_WIDTH+`TREE_GROWTH+`ITER_WIDTH:0] sq_acc_t;
    typedef logic [2*`IN_WIDTH:0] var_t;

    // Inverse square root
    typedef logic [`IN_WIDTH:0] root_t;
    typedef logic [`RECIP_FRAC:0] recip_t;

    // Normalized output
    typedef logic signed [`OUT_WIDTH-1:0] out_data_t;

endpackage

//--- tb.f
+incdir+hw
+incdir+testbench
hw/norm_types_pkg.sv
hw/norm_ctrl_pkg.sv
hw/fixed_adder_tree.sv
hw/fixed_accumulator.sv
hw/group_buffer.sv
hw/inv_sqrt_unit.sv
hw/group_norm_2d.sv
testbench/tb_group_norm_2d.sv

//--- testbench/tb_norm_vectors.svh
//////////////////////////////
// Group norm test vectors
// Group table, xorshift and reference model
//////////////////////////////

`ifndef TB_NORM_VECTORS_SVH
`define TB_NORM_VECTORS_SVH

localparam int GROUP_ELEMS = `NUM_ITERS * `COMPUTE_SIZE;
localparam int NUM_GROUPS  = 8;
localparam int ELEM_MAX    = 2**(`IN_WIDTH - 1) - 1;
localparam int ELEM_MIN    = -(2**(`IN_WIDTH - 1));
localparam int OUT_MAX     = 2**(`OUT_WIDTH - 1) - 1;
localparam int OUT_MIN     = -(2**(`OUT_WIDTH - 1));

typedef enum logic [1:0] {
    KIND_CONST,
    KIND_RAMP,
    KIND_NOISE,
    KIND_SPIKE
} pattern_kind_t;

typedef struct packed {
    pattern_kind_t      kind;
    logic signed [15:0] base;
    logic signed [15:0] step;
    logic               stall;
} group_row_t;

typedef int group_elems_t [GROUP_ELEMS];

// Kind, base, step, random out_ready
localparam group_row_t GROUP_TABLE [NUM_GROUPS] = '{
    '{KIND_CONST,  16'sd37,  16'sd0,   1'b0},
    '{KIND_RAMP,  -16'sd64,  16'sd4,   1'b0},
    '{KIND_NOISE,  16'sd0,   16'sd127, 1'b0},
    '{KIND_SPIKE,  16'sd10,  16'sd90,  1'b0},
    '{KIND_SPIKE, -16'sd20,  16'sd100, 1'b1},
    '{KIND_NOISE,  16'sd40,  16'sd20,  1'b1},
    '{KIND_CONST, -16'sd128, 16'sd0,   1'b1},
    '{KIND_RAMP,   16'sd100, -16'sd7,  1'b0}
};

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

function automatic int clamp_element(input int v);
    if (v > ELEM_MAX) begin
        return ELEM_MAX;
    end
    if (v < ELEM_MIN) begin
        return ELEM_MIN;
    end
    return v;
endfunction

function automatic int pattern_element(input group_row_t row, input int e, input logic [31:0] r);
    int base;
    int step;
    int v;
    base = int'(row.base);
    step = int'(row.step);
    case (row.kind)
        KIND_CONST: v = base;
        KIND_RAMP:  v = base + step * e;
        KIND_NOISE: v = base + (int'(r[15:0]) % (2 * step + 1)) - step;
        default: begin
            // Element 5 spikes over a little noise
            if (e == 5) begin
                v = r[4] ? base + step : base - step;
            end else begin
                v = base + int'(r[1:0]) - 1;
            end
        end
    endcase
    return clamp_element(v);
endfunction

function automatic int model_mean(input group_elems_t elems);
    int sum;
    sum = 0;
    for (int e = 0; e < GROUP_ELEMS; e++) begin
        sum += elems[e];
    end
    return sum >>> `ELEM_SHIFT;
endfunction

function automatic int model_variance(input group_elems_t elems, input int mean);
    int sum;
    sum = 0;
    for (int e = 0; e < GROUP_ELEMS; e++) begin
        sum += (elems[e] - mean) * (elems[e] - mean);
    end
    return sum >>> `ELEM_SHIFT;
endfunction

function automatic int model_recip(input int variance);
    int root;
    root = 0;
    while ((root + 1) * (root + 1) <= variance) begin
        root++;
    end
    return (1 << `RECIP_FRAC) / (root + 1);
endfunction

function automatic out_data_t model_output(input int diff, input int recip);
    int scaled;
    scaled = (diff * recip) >>> `SCALE_SHIFT;
    if (scaled > OUT_MAX) begin
        scaled = OUT_MAX;
    end else if (scaled < OUT_MIN) begin
        scaled = OUT_MIN;
    end
    return out_data_t'(scaled);
endfunction

`endif

//--- testbench/tb_group_norm_2d.sv
//////////////////////////////
// Group norm testbench
// Table-driven groups with back-pressure
//////////////////////////////

`include "group_norm_defines.svh"

module tb_group_norm_2d import norm_types_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    `include "tb_norm_vectors.svh"

    localparam int CLK_PERIOD      = 100;
    localparam int TOTAL_BEATS     = NUM_GROUPS * `NUM_ITERS;
    localparam int TOTAL_ELEMS     = NUM_GROUPS * GROUP_ELEMS;
    localparam int WATCHDOG_CYCLES = 200 * NUM_GROUPS;
    localparam int STALL_LEN       = 256;
    localparam int DRAIN_CYCLES    = 20;

    logic      clk = 1'b0;
    logic      reset;
    in_data_t  in_data [`COMPUTE_SIZE];
    logic      in_valid;
    logic      in_ready;
    out_data_t out_data [`COMPUTE_SIZE];
    logic      out_valid;
    logic      out_ready = 1'b1;

    in_data_t    stim [TOTAL_ELEMS];
    out_data_t   expected [TOTAL_ELEMS];
    logic        stall_pattern [STALL_LEN];
    logic [31:0] rng_state;
    int          in_beats = 0;
    int          out_beats = 0;
    int          stall_cycle = 0;

    group_norm_2d DUT (
        .clk(clk), .reset(reset),
        .in_data(in_data), .in_valid(in_valid), .in_ready(in_ready),
        .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_element(input int beat, input int lane,
                                 input out_data_t got, input out_data_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t: beat %0d lane %0d gave %0d, expected %0d",
                                $time, beat, lane, got, exp));
        end
    endtask

    task automatic check_count(input int group, input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("Fail at %0t: group %0d gave %0d output beats, expected %0d",
                                $time, group, got, exp));
        end
    endtask

    task automatic check_ready(input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t: in_ready was %b with a group in flight, expected %b",
                                $time, got, exp));
        end
    endtask

    // Expand the table into input elements and expected outputs
    task automatic build_vectors();
        group_elems_t elems;
        int           mean;
        int           recip;
        rng_state = 32'hd512;
        for (int g = 0; g < NUM_GROUPS; g++) begin
            for (int e = 0; e < GROUP_ELEMS; e++) begin
                rng_state = xorshift32(rng_state);
                elems[e] = pattern_element(GROUP_TABLE[g], e, rng_state);
                stim[g * GROUP_ELEMS + e] = in_data_t'(elems[e]);
            end
            mean  = model_mean(elems);
            recip = model_recip(model_variance(elems, mean));
            for (int e = 0; e < GROUP_ELEMS; e++) begin
                expected[g * GROUP_ELEMS + e] = model_output(elems[e] - mean, recip);
            end
        end
        for (int i = 0; i < STALL_LEN; i++) begin
            rng_state = xorshift32(rng_state);
            stall_pattern[i] = rng_state[16];
        end
    endtask

    // Called just after a rising edge and returns on the edge of the transfer
    task automatic drive_beat(input int beat);
        for (int lane = 0; lane < `COMPUTE_SIZE; lane++) begin
            in_data[lane] <= stim[beat * `COMPUTE_SIZE + lane];
        end
        in_valid <= 1'b1;
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    // Random out_ready only while a stalled group is coming out
    always @(posedge clk) begin
        if (out_beats < TOTAL_BEATS && GROUP_TABLE[out_beats / `NUM_ITERS].stall) begin
            out_ready   <= stall_pattern[stall_cycle % STALL_LEN];
            stall_cycle <= stall_cycle + 1;
        end else begin
            out_ready <= 1'b1;
        end
    end

    always @(negedge clk) begin
        if (!reset) begin
            // A fully loaded group blocks input until its last beat shows up
            if (in_beats > 0 && in_beats % `NUM_ITERS == 0
                    && out_beats + int'(out_valid) < in_beats) begin
                check_ready(in_ready, 1'b0);
            end
            if (in_valid && in_ready) begin
                if (in_beats > 0 && in_beats % `NUM_ITERS == 0) begin
                    check_count(in_beats / `NUM_ITERS - 1,
                                out_beats + int'(out_valid) - (in_beats - `NUM_ITERS),
                                `NUM_ITERS);
                end
                in_beats++;
            end
            if (out_valid && out_ready) begin
                if (out_beats < TOTAL_BEATS) begin
                    for (int lane = 0; lane < `COMPUTE_SIZE; lane++) begin
                        check_element(out_beats, lane, out_data[lane],
                                      expected[out_beats * `COMPUTE_SIZE + lane]);
                    end
                end
                out_beats++;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run($sformatf("The run timed out after %0d cycles", WATCHDOG_CYCLES));
    end

    initial begin
        reset    = 1'b1;
        in_valid = 1'b0;
        for (int lane = 0; lane < `COMPUTE_SIZE; lane++) begin
            in_data[lane] = '0;
        end
        build_vectors();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        // Groups go back to back and in_ready alone paces them
        for (int beat = 0; beat < TOTAL_BEATS; beat++) begin
            drive_beat(beat);
        end
        in_valid <= 1'b0;
        while (out_beats < TOTAL_BEATS) begin
            @(posedge clk);
        end
        repeat (DRAIN_CYCLES) @(posedge clk);
        check_count(NUM_GROUPS - 1, out_beats - (TOTAL_BEATS - `NUM_ITERS), `NUM_ITERS);
        $display("Done: no errors");
        $finish;
    end

endmodule
